/* spi_reg_pkg.sv */
// shared constants for the spi register peripheral
// command codes for the 8-bit command byte
// field widths of the 56-bit frame
// size of the wishbone register bank

package spi_reg_pkg;

	// frame layout, msb first
	// command byte
	localparam int cmd_width = 8;
	// register address
	localparam int addr_width = 16;
	// data word, also the wishbone data width
	localparam int data_width = 32;

	// 1 command + 2 address + 4 data bytes
	localparam int frame_bytes = 7;

	// command codes
	// the whole byte is compared, no sub-fields
	// register write, data phase carries the word
	localparam logic [cmd_width-1:0] cmd_write = 8'h01;
	// register read, word returned on miso in the data phase
	localparam logic [cmd_width-1:0] cmd_read = 8'h02;

	// register bank
	// words in the bank
	localparam int reg_count = 16;
	// low address bits that pick a word
	localparam int reg_index_width = 4;

	// anything above these bits set means out of range
	// reg_count must equal 2**reg_index_width

endpackage

/* spi_input_sync.sv */
// spi pin synchroniser
// shift registers for sck, ssel and mosi into the clock domain
// edge pulses for sck, select level and frame start pulse

module spi_input_sync (
	input  logic clock,
	input  logic rst,
	input  logic sck,
	input  logic ssel,
	input  logic mosi,
	output logic sck_rise,
	output logic sck_fall,
	output logic sel_active,
	output logic sel_start,
	output logic mosi_bit
);

	// stage 0 is the newest sample
	logic [2:0] sck_r;
	logic [2:0] sel_r;
	logic [1:0] mosi_r;

	always_ff @(posedge clock) begin
		if (rst) begin
			sck_r <= '0;
			// ssel idles high, so no frame right after reset
			sel_r <= '1;
			mosi_r <= '0;
		end else begin
			sck_r <= {sck_r[1:0], sck};
			sel_r <= {sel_r[1:0], ssel};
			mosi_r <= {mosi_r[0], mosi};
		end
	end

	// edges from the two older stages only
	assign sck_rise = (sck_r[2:1] == 2'b01);
	assign sck_fall = (sck_r[2:1] == 2'b10);
	// ssel is active low
	assign sel_active = ~sel_r[1];
	// falling ssel opens a frame
	assign sel_start = (sel_r[2:1] == 2'b10);
	// lines up with the sck stage used for the edges
	assign mosi_bit = mosi_r[1];

endmodule

/* spi_frame_port.sv */
// spi mode 0 frame receiver and transmitter
// bit and byte counters, cleared while ssel is high
// command, address and write data field assembly
// addr_done and frame_done pulses for the bus bridge
// 32-bit miso shifter loaded with read data at the data phase

module spi_frame_port (
	input  logic clock,
	input  logic rst,
	input  logic sck,
	input  logic ssel,
	input  logic mosi,
	input  logic [spi_reg_pkg::data_width-1:0] read_data,
	output logic miso,
	output logic [spi_reg_pkg::cmd_width-1:0] command,
	output logic [spi_reg_pkg::addr_width-1:0] address,
	output logic [spi_reg_pkg::data_width-1:0] write_data,
	output logic addr_done,
	output logic frame_done
);

	logic sck_rise;
	logic sck_fall;
	logic sel_active;
	logic sel_start;
	logic mosi_bit;

	// counts 0 to 8, 8 means a byte is waiting to be steered
	logic [3:0] bit_count;
	// counts 0 to frame_bytes and then stops
	logic [2:0] byte_count;
	logic [spi_reg_pkg::cmd_width-1:0] rx_byte;
	logic [spi_reg_pkg::data_width-1:0] tx_shift;
	logic byte_done;
	logic tx_load;

	spi_input_sync sync0 (
		.clock(clock),
		.rst(rst),
		.sck(sck),
		.ssel(ssel),
		.mosi(mosi),
		.sck_rise(sck_rise),
		.sck_fall(sck_fall),
		.sel_active(sel_active),
		.sel_start(sel_start),
		.mosi_bit(mosi_bit)
	);

	// one clock after the eighth rising edge
	assign byte_done = sel_active && !sck_rise && (bit_count == 4'd8);

	// counters and the two strobes
	always_ff @(posedge clock) begin
		addr_done <= 1'b0;
		frame_done <= 1'b0;
		if (rst || !sel_active) begin
			// aborted frame ends here, no frame_done
			bit_count <= '0;
			byte_count <= '0;
		end else if (sck_rise) begin
			bit_count <= bit_count + 4'd1;
		end else if (byte_done) begin
			bit_count <= '0;
			// extra bytes past the frame are dropped
			if (byte_count != 3'(spi_reg_pkg::frame_bytes)) begin
				byte_count <= byte_count + 3'd1;
			end
			// third byte ends the address
			addr_done <= (byte_count == 3'd2);
			// last data byte
			frame_done <= (byte_count == 3'(spi_reg_pkg::frame_bytes - 1));
		end
	end

	// msb first, so shift left
	always_ff @(posedge clock) begin
		if (sel_active && sck_rise) begin
			rx_byte <= {rx_byte[spi_reg_pkg::cmd_width-2:0], mosi_bit};
		end
	end

	// command decides whether a bus cycle starts
	always_ff @(posedge clock) begin
		if (rst) begin
			command <= '0;
		end else if (byte_done && byte_count == 3'd0) begin
			command <= rx_byte;
		end
	end

	// address and data fields, held until the next frame
	always_ff @(posedge clock) begin
		if (byte_done) begin
			case (byte_count)
				3'd1: address[15:8] <= rx_byte;
				3'd2: address[7:0] <= rx_byte;
				3'd3: write_data[31:24] <= rx_byte;
				3'd4: write_data[23:16] <= rx_byte;
				3'd5: write_data[15:8] <= rx_byte;
				3'd6: write_data[7:0] <= rx_byte;
				default: ;
			endcase
		end
	end

	// start of the data phase
	// held for the whole sck low time, so late read data still lands
	assign tx_load = (byte_count == 3'd3) && (bit_count == 4'd0);

	always_ff @(posedge clock) begin
		if (rst || sel_start) begin
			tx_shift <= '0;
		end else if (sel_active) begin
			if (tx_load) begin
				// load wins over the falling edge after the last address bit
				tx_shift <= read_data;
			end else if (sck_fall) begin
				tx_shift <= {tx_shift[spi_reg_pkg::data_width-2:0], 1'b0};
			end
		end
	end

	// single peripheral, miso always driven
	assign miso = tx_shift[spi_reg_pkg::data_width-1];

endmodule

/* spi_wb_bridge.sv */
// spi frame to wishbone classic master
// command decode against the read and write codes
// idle, strobe and wait-for-ack sequence
// read data capture on the ack of a read

module spi_wb_bridge (
	input  logic clock,
	input  logic rst,
	input  logic [spi_reg_pkg::cmd_width-1:0] command,
	input  logic [spi_reg_pkg::addr_width-1:0] address,
	input  logic [spi_reg_pkg::data_width-1:0] write_data,
	input  logic addr_done,
	input  logic frame_done,
	input  logic wb_ack,
	input  logic [spi_reg_pkg::data_width-1:0] wb_dat_r,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output logic [spi_reg_pkg::addr_width-1:0] wb_adr,
	output logic [spi_reg_pkg::data_width-1:0] wb_dat_w,
	output logic [spi_reg_pkg::data_width-1:0] read_data
);

	// 0 idle, 1 first strobe cycle, 2 waiting for ack
	logic [1:0] phase;
	logic start_read;
	logic start_write;

	// reads go out as soon as the address is in
	assign start_read = addr_done && (command == spi_reg_pkg::cmd_read);
	// writes need the whole data word
	assign start_write = frame_done && (command == spi_reg_pkg::cmd_write);

	always_ff @(posedge clock) begin
		if (rst) begin
			phase <= 2'd0;
			wb_cyc <= 1'b0;
			wb_stb <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			case (phase)
				2'd0: begin
					// trigger while busy is simply lost
					if (start_read || start_write) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we <= start_write;
						phase <= 2'd1;
					end
				end
				default: begin
					// hold cyc and stb until the slave answers
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						phase <= 2'd0;
					end else begin
						phase <= 2'd2;
					end
				end
			endcase
		end
	end

	// bus address and data, latched with the start of a cycle
	always_ff @(posedge clock) begin
		if (phase == 2'd0 && (start_read || start_write)) begin
			wb_adr <= address;
			wb_dat_w <= write_data;
		end
	end

	// kept until the next read, the miso shifter picks it up
	always_ff @(posedge clock) begin
		if (phase != 2'd0 && wb_ack && !wb_we) begin
			read_data <= wb_dat_r;
		end
	end

endmodule

/* wb_reg_bank.sv */
// wishbone classic slave with 16 registers of 32 bits
// one-clock ack for every cycle, any address
// out of range addresses write nothing and read zero

module wb_reg_bank (
	input  logic clock,
	input  logic rst,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [spi_reg_pkg::addr_width-1:0] wb_adr,
	input  logic [spi_reg_pkg::data_width-1:0] wb_dat_w,
	output logic wb_ack,
	output logic [spi_reg_pkg::data_width-1:0] wb_dat_r
);

	logic [spi_reg_pkg::data_width-1:0] regs [spi_reg_pkg::reg_count];
	logic [spi_reg_pkg::reg_index_width-1:0] index;
	logic in_range;
	logic accept;

	assign index = wb_adr[spi_reg_pkg::reg_index_width-1:0];
	// all upper address bits must be zero
	assign in_range = (wb_adr[spi_reg_pkg::addr_width-1:spi_reg_pkg::reg_index_width] == '0);
	// new strobe, not the cycle we already acked
	assign accept = wb_cyc && wb_stb && !wb_ack;

	// ack is a single clock pulse
	always_ff @(posedge clock) begin
		if (rst) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < spi_reg_pkg::reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (accept && wb_we && in_range) begin
			regs[index] <= wb_dat_w;
		end
	end

	// read word presented together with ack
	always_ff @(posedge clock) begin
		if (accept) begin
			wb_dat_r <= in_range ? regs[index] : '0;
		end
	end

endmodule

/* spi_reg_top.sv */
// spi register peripheral top level
// spi frame port, wishbone bridge and register bank

module spi_reg_top (
	input  logic clock,
	input  logic rst,
	input  logic sck,
	input  logic ssel,
	input  logic mosi,
	output logic miso
);

	// frame port to bridge
	logic [spi_reg_pkg::cmd_width-1:0] command;
	logic [spi_reg_pkg::addr_width-1:0] address;
	logic [spi_reg_pkg::data_width-1:0] write_data;
	logic addr_done;
	logic frame_done;
	// bridge back to frame port
	logic [spi_reg_pkg::data_width-1:0] read_data;

	// wishbone classic between bridge and bank
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [spi_reg_pkg::addr_width-1:0] wb_adr;
	logic [spi_reg_pkg::data_width-1:0] wb_dat_w;
	logic wb_ack;
	logic [spi_reg_pkg::data_width-1:0] wb_dat_r;

	spi_frame_port port0 (
		.clock(clock),
		.rst(rst),
		.sck(sck),
		.ssel(ssel),
		.mosi(mosi),
		.read_data(read_data),
		.miso(miso),
		.command(command),
		.address(address),
		.write_data(write_data),
		.addr_done(addr_done),
		.frame_done(frame_done)
	);

	spi_wb_bridge bridge0 (
		.clock(clock),
		.rst(rst),
		.command(command),
		.address(address),
		.write_data(write_data),
		.addr_done(addr_done),
		.frame_done(frame_done),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.read_data(read_data)
	);

	wb_reg_bank bank0 (
		.clock(clock),
		.rst(rst),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_ack(wb_ack),
		.wb_dat_r(wb_dat_r)
	);

endmodule

/* tb_clock_gen.sv */
// testbench clock source, 100 ns period
// reset sequencer, rst held high for the first 8 clocks

module tb_clock_gen (
	output logic clock,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int half_period_ns = 50;
	localparam int reset_cycles = 8;

	initial begin
		clock = 1'b0;
		forever #(half_period_ns) clock = ~clock;
	end

	// release lines up with a rising edge
	initial begin
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clock);
		rst <= 1'b0;
	end

endmodule

/* spi_reg_tb.sv */
// testbench for the spi register peripheral
// spi mode 0 controller driver counted in system clocks
// register model with the same range rules as the bank
// word compare task, watchdog and the five test phases

module spi_reg_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// sck half period in clocks
	localparam int sck_half = 10;
	localparam int clock_period_ns = 100;
	localparam int frame_bits = spi_reg_pkg::cmd_width + spi_reg_pkg::addr_width
		+ spi_reg_pkg::data_width;
	// idle clocks after ssel goes high, lets a write land
	localparam int frame_gap = 2 * sck_half;

	// frames per test phase
	localparam int reset_frames = spi_reg_pkg::reg_count;
	localparam int pair_count = 4;
	localparam int random_ops = 200;
	localparam int junk_frames = 20;
	localparam int abort_rounds = 8;
	localparam int frames_planned = reset_frames + 2 * pair_count + random_ops
		+ junk_frames + spi_reg_pkg::reg_count + 4 * abort_rounds;
	// bits times clocks per bit times period, plus half again
	localparam longint timeout_ns = longint'(frames_planned) * frame_bits * 2 * sck_half
		* clock_period_ns * 3 / 2;

	logic clock;
	logic rst;
	logic sck;
	logic ssel;
	logic mosi;
	logic miso;

	// expected register contents, index is the word address
	logic [spi_reg_pkg::data_width-1:0] model_mem [int];

	tb_clock_gen clock_gen0 (
		.clock(clock),
		.rst(rst)
	);

	spi_reg_top dut0 (
		.clock(clock),
		.rst(rst),
		.sck(sck),
		.ssel(ssel),
		.mosi(mosi),
		.miso(miso)
	);

	// writes to out of range addresses are dropped
	function automatic void store_expected(input logic [spi_reg_pkg::addr_width-1:0] addr,
		input logic [spi_reg_pkg::data_width-1:0] data);
		if (addr < spi_reg_pkg::reg_count) begin
			model_mem[int'(addr)] = data;
		end
	endfunction

	// out of range reads give zero
	function automatic logic [spi_reg_pkg::data_width-1:0] expected_word(
		input logic [spi_reg_pkg::addr_width-1:0] addr);
		if (addr < spi_reg_pkg::reg_count && model_mem.exists(int'(addr))) begin
			return model_mem[int'(addr)];
		end
		return '0;
	endfunction

	task automatic check_word(input logic [spi_reg_pkg::data_width-1:0] expected,
		input logic [spi_reg_pkg::data_width-1:0] actual,
		input logic [spi_reg_pkg::addr_width-1:0] addr);
		if (actual !== expected) begin
			$display("error %0d ns: read of address 0x%04h gave 0x%08h, expected 0x%08h",
				$time, addr, actual, expected);
			$display("Test failed");
			$fatal(1, "register read mismatch");
		end
	endtask

	// one frame, msb first, cut short when bits_sent is below frame_bits
	task automatic spi_frame(input logic [spi_reg_pkg::cmd_width-1:0] cmd,
		input logic [spi_reg_pkg::addr_width-1:0] addr,
		input logic [spi_reg_pkg::data_width-1:0] data,
		input int bits_sent,
		output logic [spi_reg_pkg::data_width-1:0] rx_word);
		logic [frame_bits-1:0] tx_bits;
		logic [frame_bits-1:0] rx_bits;
		tx_bits = {cmd, addr, data};
		rx_bits = '0;
		@(posedge clock);
		ssel <= 1'b0;
		sck <= 1'b0;
		mosi <= tx_bits[frame_bits-1];
		for (int n = 0; n < bits_sent; n++) begin
			// sck low, miso taken in the last low clock
			repeat (sck_half - 1) @(posedge clock);
			@(negedge clock);
			rx_bits = {rx_bits[frame_bits-2:0], miso};
			@(posedge clock);
			sck <= 1'b1;
			repeat (sck_half) @(posedge clock);
			sck <= 1'b0;
			// next bit goes out with the falling edge
			if (n < frame_bits - 1) begin
				mosi <= tx_bits[frame_bits-2-n];
			end
		end
		repeat (sck_half) @(posedge clock);
		ssel <= 1'b1;
		mosi <= 1'b0;
		repeat (frame_gap) @(posedge clock);
		// data phase is the last 32 samples
		rx_word = rx_bits[spi_reg_pkg::data_width-1:0];
	endtask

	task automatic write_register(input logic [spi_reg_pkg::addr_width-1:0] addr,
		input logic [spi_reg_pkg::data_width-1:0] data);
		logic [spi_reg_pkg::data_width-1:0] unused_rx;
		spi_frame(spi_reg_pkg::cmd_write, addr, data, frame_bits, unused_rx);
		store_expected(addr, data);
	endtask

	// data sent during a read is noise on purpose
	task automatic read_and_check(input logic [spi_reg_pkg::addr_width-1:0] addr);
		logic [spi_reg_pkg::data_width-1:0] got;
		spi_frame(spi_reg_pkg::cmd_read, addr, $urandom, frame_bits, got);
		check_word(expected_word(addr), got, addr);
	endtask

	initial begin
		#(timeout_ns);
		$display("timeout: the SPI frames did not finish within %0d ns", timeout_ns);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [spi_reg_pkg::addr_width-1:0] addr;
		logic [spi_reg_pkg::data_width-1:0] data;
		logic [spi_reg_pkg::cmd_width-1:0] cmd;
		logic [spi_reg_pkg::data_width-1:0] rx;
		int stop_bit;
		sck = 1'b0;
		ssel = 1'b1;
		mosi = 1'b0;
		void'($urandom(53048));
		for (int i = 0; i < spi_reg_pkg::reg_count; i++) begin
			model_mem[i] = '0;
		end
		wait (rst === 1'b0);
		repeat (4) @(posedge clock);

		// bank is all zero after reset
		for (int i = 0; i < reset_frames; i++) begin
			read_and_check(16'(i));
		end

		// write then read back
		for (int i = 0; i < pair_count; i++) begin
			addr = 16'($urandom_range(spi_reg_pkg::reg_count - 1, 0));
			data = $urandom;
			write_register(addr, data);
			read_and_check(addr);
		end

		// mixed traffic, half the addresses out of range
		for (int i = 0; i < random_ops; i++) begin
			addr = 16'($urandom_range(31, 0));
			if ($urandom_range(1, 0) == 1) begin
				write_register(addr, $urandom);
			end else begin
				read_and_check(addr);
			end
		end

		// unknown commands must leave the bank alone
		for (int i = 0; i < junk_frames; i++) begin
			do begin
				cmd = 8'($urandom);
			end while (cmd == spi_reg_pkg::cmd_write || cmd == spi_reg_pkg::cmd_read);
			addr = 16'($urandom_range(spi_reg_pkg::reg_count - 1, 0));
			spi_frame(cmd, addr, $urandom, frame_bits, rx);
		end
		for (int i = 0; i < spi_reg_pkg::reg_count; i++) begin
			read_and_check(16'(i));
		end

		// write cut off by ssel, then a full frame
		for (int i = 0; i < abort_rounds; i++) begin
			addr = 16'($urandom_range(spi_reg_pkg::reg_count - 1, 0));
			data = $urandom;
			stop_bit = $urandom_range(frame_bits - 1, 1);
			spi_frame(spi_reg_pkg::cmd_write, addr, data, stop_bit, rx);
			read_and_check(addr);
			write_register(addr, data);
			read_and_check(addr);
		end

		$display("Test passed");
		$finish;
	end

endmodule

/* project.f */
spi_reg_pkg.sv
spi_input_sync.sv
spi_frame_port.sv
spi_wb_bridge.sv
wb_reg_bank.sv
spi_reg_top.sv
tb_clock_gen.sv
spi_reg_tb.sv
